/* design/md5_cfg.svh */
`ifndef MD5_CFG_SVH
`define MD5_CFG_SVH

// queue side
`define MD5_QUEUE_WIDTH 512

// hash side
`define MD5_DIGEST_WIDTH 128
`define MD5_DIGESTS_PER_WORD 4
`define MD5_STEPS_PER_STAGE 16

`endif

/* design/md5_pkg.sv */
package md5_pkg;

  `include "md5_cfg.svh"

  typedef logic [31:0] word_t;
  typedef logic [`MD5_QUEUE_WIDTH-1:0] block_t;
  typedef logic [`MD5_DIGEST_WIDTH-1:0] digest_t; // a in 31:0, d in 127:96

  typedef enum logic [1:0] {
    ROUND_F,
    ROUND_G,
    ROUND_H,
    ROUND_I
  } round_e;

  typedef enum logic {
    STAGE_IDLE,
    STAGE_BUSY
  } stage_state_e;

  // standard chaining value, a..d from the low bits up
  localparam digest_t md5_init = {32'h10325476, 32'h98badcfe, 32'hefcdab89, 32'h67452301};

  // floor(abs(sin(i + 1)) * 2^32)
  localparam word_t MD5_K_TABLE [64] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee, // round f
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa, // round g
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c, // round h
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039, // round i
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // rotate amounts repeat every four steps within a round
  localparam logic [4:0] MD5_S_TABLE [4][4] = '{
    '{5'd7, 5'd12, 5'd17, 5'd22},
    '{5'd5, 5'd9,  5'd14, 5'd20},
    '{5'd4, 5'd11, 5'd16, 5'd23},
    '{5'd6, 5'd10, 5'd15, 5'd21}
  };

  function automatic word_t md5_k(logic [5:0] step);
    return MD5_K_TABLE[step];
  endfunction

  function automatic logic [4:0] md5_shift(round_e round, logic [5:0] step);
    return MD5_S_TABLE[round][step[1:0]];
  endfunction

endpackage

/* design/md5_block_loader.sv */
`timescale 1ns/1ps

`include "md5_cfg.svh"

module md5_block_loader import md5_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   start,
  input  logic   available_read,
  input  logic   available_write,
  input  logic   read_data_valid,
  input  logic   done_rd_data,
  input  logic   done_wr_data,
  input  block_t read_data,
  output logic   request_read,
  output logic   blk_valid,
  output block_t blk_data,
  output logic   done
);

  localparam logic [4:0] SPACING = 5'(`MD5_STEPS_PER_STAGE);

  logic       pending_q; // one read in flight
  logic [4:0] gap_q;     // cycles since last strobe, saturates
  logic       issue;

  assign issue = start && available_read && available_write && !pending_q
                 && (gap_q >= SPACING);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      request_read <= 1'b0;
      pending_q    <= 1'b0;
      gap_q        <= SPACING; // first read may go at once
      blk_valid    <= 1'b0;
      done         <= 1'b0;
    end else begin
      request_read <= issue;
      blk_valid    <= read_data_valid;
      done         <= done_rd_data & done_wr_data;
      if (issue) begin
        pending_q <= 1'b1;
      end else if (read_data_valid) begin
        pending_q <= 1'b0;
      end
      if (read_data_valid) begin
        gap_q <= '0; // strobe into stage 0 lands next cycle
      end else if (gap_q < SPACING) begin
        gap_q <= gap_q + 5'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read_data_valid) begin
      blk_data <= read_data;
    end
  end

  // the queue answers each request exactly once
  a_no_stray_data: assert property (
    @(posedge clk) disable iff (!arst_n) read_data_valid |-> pending_q
  ) else $error("read_data_valid with no read outstanding");

endmodule

/* design/md5_round_stage.sv */
`timescale 1ns/1ps

`include "md5_cfg.svh"

module md5_round_stage import md5_pkg::*; #(
  parameter round_e ROUND = ROUND_F
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    in_valid,
  input  block_t  in_block,
  input  digest_t in_state,
  output logic    out_valid,
  output block_t  out_block,
  output digest_t out_state
);

  localparam logic [3:0] LAST_STEP = 4'(`MD5_STEPS_PER_STAGE - 1);
  localparam logic [1:0] ROUND_IDX = ROUND;

  stage_state_e state_q;
  logic [3:0]   cnt_q;
  block_t       blk_q;
  word_t        a_q, b_q, c_q, d_q;

  logic       load;
  logic       step_en;
  block_t     blk_s;
  word_t      a_s, b_s, c_s, d_s;
  logic [3:0] step_s;
  logic [5:0] k_idx;
  logic [3:0] g;
  logic [4:0] sh;
  word_t      f;
  word_t      sum_w;
  word_t      rot_w;
  word_t      b_new;

  assign load    = (state_q == STAGE_IDLE) && in_valid;
  assign step_en = load || (state_q == STAGE_BUSY);

  // step 0 runs straight off the inputs in the load cycle
  always_comb begin
    blk_s  = load ? in_block : blk_q;
    a_s    = load ? in_state[31:0] : a_q;
    b_s    = load ? in_state[63:32] : b_q;
    c_s    = load ? in_state[95:64] : c_q;
    d_s    = load ? in_state[127:96] : d_q;
    step_s = load ? 4'd0 : cnt_q;
    k_idx  = {ROUND_IDX, step_s};
    case (ROUND)
      ROUND_F: begin
        f = (b_s & c_s) | (~b_s & d_s);
        g = step_s;
      end
      ROUND_G: begin
        f = (b_s & d_s) | (c_s & ~d_s);
        g = step_s * 4'd5 + 4'd1; // wraps mod 16
      end
      ROUND_H: begin
        f = b_s ^ c_s ^ d_s;
        g = step_s * 4'd3 + 4'd5;
      end
      default: begin
        f = c_s ^ (b_s | ~d_s);
        g = step_s * 4'd7;
      end
    endcase
    sh    = md5_shift(ROUND, k_idx);
    sum_w = a_s + f + md5_k(k_idx) + blk_s[32*g +: 32];
    rot_w = (sum_w << sh) | (sum_w >> (6'd32 - {1'b0, sh}));
    b_new = b_s + rot_w;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= STAGE_IDLE;
      cnt_q     <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      case (state_q)
        STAGE_IDLE: begin
          if (in_valid) begin
            state_q <= STAGE_BUSY;
            cnt_q   <= 4'd1;
          end
        end
        default: begin
          if (cnt_q == LAST_STEP) begin
            state_q   <= STAGE_IDLE;
            out_valid <= 1'b1; // 16 cycles after in_valid
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      blk_q <= in_block;
    end
    if (step_en) begin
      a_q <= d_s;
      b_q <= b_new;
      c_q <= b_s;
      d_q <= c_s;
    end
  end

  // held until the next load, which the loader spacing keeps away
  assign out_block = blk_q;
  assign out_state = {d_q, c_q, b_q, a_q};

  // loader spacing must keep new blocks away from a busy stage
  a_no_overrun: assert property (
    @(posedge clk) disable iff (!arst_n) in_valid |-> state_q == STAGE_IDLE
  ) else $error("block arrived while stage busy");

endmodule

/* design/md5_digest_packer.sv */
`timescale 1ns/1ps

`include "md5_cfg.svh"

module md5_digest_packer import md5_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    dig_valid,
  input  digest_t dig_state,
  output logic    request_write,
  output block_t  write_data
);

  localparam int SLOTS = `MD5_DIGESTS_PER_WORD;
  localparam int DW    = `MD5_DIGEST_WIDTH;
  localparam logic [1:0] LAST_SLOT = 2'(SLOTS - 1);

  logic [1:0] slot_q;
  digest_t    slots_q [SLOTS-1]; // digests waiting for the rest of the word
  digest_t    sum;
  block_t     packed_word;

  always_comb begin
    for (int w = 0; w < 4; w++) begin
      sum[32*w +: 32] = dig_state[32*w +: 32] + md5_init[32*w +: 32];
    end
    for (int s = 0; s < SLOTS - 1; s++) begin
      packed_word[DW*s +: DW] = slots_q[s];
    end
    packed_word[DW*(SLOTS-1) +: DW] = sum; // newest digest on top
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_q        <= '0;
      request_write <= 1'b0;
      write_data    <= '0;
    end else begin
      request_write <= 1'b0;
      if (dig_valid) begin
        if (slot_q == LAST_SLOT) begin
          write_data    <= packed_word;
          request_write <= 1'b1;
          slot_q        <= '0;
        end else begin
          slot_q <= slot_q + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dig_valid && (slot_q != LAST_SLOT)) begin
      slots_q[slot_q] <= sum;
    end
  end

endmodule

/* design/md5_accel_top.sv */
`timescale 1ns/1ps

module md5_accel_top import md5_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   start,
  input  logic   available_read,
  input  logic   available_write,
  input  logic   read_data_valid,
  input  block_t read_data,
  input  logic   done_rd_data,
  input  logic   done_wr_data,
  output logic   request_read,
  output logic   request_write,
  output block_t write_data,
  output logic   done
);

  localparam int NUM_ROUNDS = 4;

  // index i feeds stage i, index NUM_ROUNDS feeds the packer
  logic    stg_valid [NUM_ROUNDS+1];
  block_t  stg_block [NUM_ROUNDS+1];
  digest_t stg_state [NUM_ROUNDS+1];

  assign stg_state[0] = md5_init;

  md5_block_loader u_loader (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (start),
    .available_read  (available_read),
    .available_write (available_write),
    .read_data_valid (read_data_valid),
    .done_rd_data    (done_rd_data),
    .done_wr_data    (done_wr_data),
    .read_data       (read_data),
    .request_read    (request_read),
    .blk_valid       (stg_valid[0]),
    .blk_data        (stg_block[0]),
    .done            (done)
  );

  for (genvar i = 0; i < NUM_ROUNDS; i++) begin : g_round
    md5_round_stage #(
      .ROUND (round_e'(i))
    ) u_stage (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (stg_valid[i]),
      .in_block  (stg_block[i]),
      .in_state  (stg_state[i]),
      .out_valid (stg_valid[i+1]),
      .out_block (stg_block[i+1]),
      .out_state (stg_state[i+1])
    );
  end

  md5_digest_packer u_packer (
    .clk           (clk),
    .arst_n        (arst_n),
    .dig_valid     (stg_valid[NUM_ROUNDS]),
    .dig_state     (stg_state[NUM_ROUNDS]),
    .request_write (request_write),
    .write_data    (write_data)
  );

endmodule

/* testbench/tb_md5_accel.sv */
`timescale 1ns/1ps

module tb_md5_accel import md5_pkg::*; ();

  // d41d8cd98f00b204e9800998ecf8427e, words a..d from the low bits up
  localparam digest_t KNOWN_DIGEST = 128'h7e42f8ec_980980e9_04b2008f_d98c1dd4;
  localparam block_t  EMPTY_BLOCK  = 512'h80; // padded empty message

  logic   clk = 1'b0;
  logic   arst_n;
  logic   start;
  logic   available_read = 1'b0;
  logic   available_write;
  logic   read_data_valid = 1'b0;
  block_t read_data = '0;
  logic   done_rd_data;
  logic   done_wr_data;
  logic   request_read;
  logic   request_write;
  block_t write_data;
  logic   done;

  integer  seed = 32'hbd88;
  block_t  in_q [$];  // blocks the input queue still holds
  digest_t exp_q [$]; // digests owed by the DUT, oldest first
  block_t  last_word;
  int      rd_wait = 0;
  int      writes_seen = 0;
  int      accepts = 0;
  int      cyc = 0;
  int      last_req_cyc = 0;
  logic    seen_req = 1'b0;
  logic    rd_enable = 1'b0;
  logic    fixed_lat = 1'b0;

  md5_accel_top UUT (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (start),
    .available_read  (available_read),
    .available_write (available_write),
    .read_data_valid (read_data_valid),
    .read_data       (read_data),
    .done_rd_data    (done_rd_data),
    .done_wr_data    (done_wr_data),
    .request_read    (request_read),
    .request_write   (request_write),
    .write_data      (write_data),
    .done            (done)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_block(input string name, input block_t exp_v, input block_t act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_digest(input string name, input digest_t exp_v, input digest_t act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp_v, act_v));
    end
  endtask

  // straight from the MD5 definition, constants rebuilt from sin
  function automatic digest_t md5_ref(input block_t blk);
    int          shifts [16];
    word_t       a, b, c, d, f, m, k, t;
    int          i, g, s;
    real         r;
    logic [63:0] kv;
    shifts = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
    a = 32'h67452301;
    b = 32'hefcdab89;
    c = 32'h98badcfe;
    d = 32'h10325476;
    for (i = 0; i < 64; i++) begin
      if (i < 16) begin
        f = (b & c) | (~b & d);
        g = i;
      end else if (i < 32) begin
        f = (d & b) | (~d & c);
        g = (5 * i + 1) % 16;
      end else if (i < 48) begin
        f = b ^ c ^ d;
        g = (3 * i + 5) % 16;
      end else begin
        f = c ^ (b | ~d);
        g = (7 * i) % 16;
      end
      r = $sin(real'(i + 1));
      if (r < 0.0) begin
        r = -r;
      end
      kv = $floor(r * 4294967296.0);
      k = kv[31:0];
      m = blk[32*g +: 32];
      s = shifts[4 * (i / 16) + i % 4];
      t = a + f + k + m;
      t = (t << s) | (t >> (32 - s));
      a = d;
      d = c;
      c = b;
      b = b + t;
    end
    return {d + 32'h10325476, c + 32'h98badcfe, b + 32'hefcdab89, a + 32'h67452301};
  endfunction

  function automatic block_t random_block();
    block_t b;
    for (int j = 0; j < 16; j++) begin
      b[32*j +: 32] = $random(seed);
    end
    return b;
  endfunction

  task automatic send_block(input block_t b);
    in_q.push_back(b);
    exp_q.push_back(md5_ref(b));
  endtask

  // input queue, answers each request once after 1 to 6 cycles
  always @(negedge clk) begin
    read_data_valid = 1'b0;
    if (rd_wait > 0) begin
      rd_wait = rd_wait - 1;
      if (rd_wait == 0) begin
        read_data_valid = 1'b1;
        read_data = in_q.pop_front();
      end
    end else if (request_read) begin
      if (in_q.size() == 0) begin
        abort_run("read request arrived with no block left in the input queue");
      end else begin
        rd_wait = fixed_lat ? 1 : 1 + ($unsigned($random(seed)) % 6);
      end
    end
    available_read = rd_enable && (in_q.size() > 0);
  end

  // output queue, every write is four digests in block order
  always @(negedge clk) begin
    if (request_write) begin
      for (int sl = 0; sl < 4; sl++) begin
        if (exp_q.size() == 0) begin
          abort_run("write arrived with no block owed");
        end else begin
          check_digest($sformatf("write %0d slot %0d", writes_seen, sl), exp_q.pop_front(),
                       write_data[$bits(digest_t)*sl +: $bits(digest_t)]);
        end
      end
      last_word = write_data;
      writes_seen = writes_seen + 1;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (read_data_valid) begin
      accepts <= accepts + 1; // block enters the loader
    end
  end

  always @(negedge clk) begin
    if (request_read) begin
      if (seen_req && (cyc - last_req_cyc < 16)) begin
        abort_run($sformatf("read requests only %0d cycles apart", cyc - last_req_cyc));
      end else begin
        seen_req = 1'b1;
        last_req_cyc = cyc;
      end
    end
  end

  task automatic wait_writes(input int target, input int limit);
    int n;
    n = 0;
    while (writes_seen < target) begin
      if (n >= limit) begin
        abort_run("expected write never arrived");
      end else begin
        @(negedge clk);
        n = n + 1;
      end
    end
  endtask

  task automatic wait_accepts(input int target, input int limit);
    int n;
    n = 0;
    while (accepts < target) begin
      if (n >= limit) begin
        abort_run("expected read request never arrived");
      end else begin
        @(negedge clk);
        n = n + 1;
      end
    end
  endtask

  task automatic gate_window(input string name, input int w0);
    repeat (100) begin
      @(negedge clk);
      check_bit(name, 1'b0, request_read);
      check_bit({name, "_no_write"}, 1'b1, writes_seen == w0);
    end
  endtask

  initial begin
    int   w0, c0, c1, c2, i;
    logic prev;
    arst_n = 1'b0;
    start = 1'b0;
    available_write = 1'b0;
    done_rd_data = 1'b0;
    done_wr_data = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_bit("reset_request_read", 1'b0, request_read);
      check_bit("reset_request_write", 1'b0, request_write);
      check_bit("reset_done", 1'b0, done);
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_bit("post_reset_request_read", 1'b0, request_read);
    check_bit("post_reset_request_write", 1'b0, request_write);
    check_bit("post_reset_done", 1'b0, done);

    check_digest("known_ref", KNOWN_DIGEST, md5_ref(EMPTY_BLOCK));
    repeat (4) send_block(EMPTY_BLOCK);
    rd_enable = 1'b1;
    available_write = 1'b1;
    start = 1'b1;
    wait_writes(1, 2000);
    check_block("known_word", {4{KNOWN_DIGEST}}, last_word);

    repeat (12) send_block(random_block());
    wait_writes(4, 4000);

    start = 1'b0; // blocks wait in the queue while gated
    repeat (4) send_block(random_block());
    w0 = writes_seen;
    gate_window("gate_start", w0);
    start = 1'b1;
    available_write = 1'b0;
    gate_window("gate_write", w0);
    rd_enable = 1'b0;
    @(negedge clk);
    available_write = 1'b1;
    gate_window("gate_read", w0);
    rd_enable = 1'b1;
    wait_writes(w0 + 1, 2000);

    fixed_lat = 1'b1;
    c0 = accepts;
    repeat (4) send_block(random_block());
    wait_accepts(c0 + 1, 200);
    c1 = cyc;
    wait_accepts(c0 + 2, 200);
    c2 = cyc;
    check_bit("two_blocks_within_64", 1'b1, (c2 - c1) < 64);
    wait_writes(w0 + 2, 2000);
    check_bit("all_digests_written", 1'b1, exp_q.size() == 0);

    for (i = 0; i < 4; i++) begin
      prev = done_rd_data & done_wr_data;
      done_rd_data = i[1];
      done_wr_data = i[0];
      #1; // mid low phase, inputs already settled
      check_bit("done_hold", prev, done);
      @(negedge clk);
      check_bit("done_follow", i[1] & i[0], done);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
design/md5_pkg.sv
design/md5_block_loader.sv
design/md5_round_stage.sv
design/md5_digest_packer.sv
design/md5_accel_top.sv
testbench/tb_md5_accel.sv

/* Bender.yml */
package:
  name: md5_accel

export_include_dirs:
  - design

sources:
  - design/md5_pkg.sv
  - design/md5_block_loader.sv
  - design/md5_round_stage.sv
  - design/md5_digest_packer.sv
  - design/md5_accel_top.sv
  - target: simulation
    files:
      - testbench/tb_md5_accel.sv
